/* logic/snax_macros.svh */
`ifndef SNAX_MACROS_SVH
`define SNAX_MACROS_SVH

// ------------------------------
// Datapath and channel widths
// ------------------------------
`define SNAX_DATA_WIDTH   64
`define SNAX_ID_WIDTH     5
`define SNAX_ADDR_WIDTH   2
`define SNAX_OP_WIDTH     4

// Entries per queue in the shell
`define SNAX_QUEUE_DEPTH  4

// Target field value of this accelerator
`define SNAX_ACC_ADDR     2

// ------------------------------
// Opcodes, low nibble of data_op
// ------------------------------
`define SNAX_OP_ADD       4'd0
`define SNAX_OP_SUB       4'd1
`define SNAX_OP_AND       4'd2
`define SNAX_OP_OR        4'd3
`define SNAX_OP_XOR       4'd4
`define SNAX_OP_MUL       4'd5
`define SNAX_OP_MAC       4'd6
`define SNAX_OP_CLR       4'd7

`endif

/* logic/snax_pkg.sv */
`include "snax_macros.svh"

package snax_pkg;

    // ------------------------------
    // Scalar field types
    // ------------------------------
    typedef logic [`SNAX_ADDR_WIDTH-1:0] acc_addr_t;
    typedef logic [`SNAX_ID_WIDTH-1:0]   acc_id_t;
    typedef logic [`SNAX_DATA_WIDTH-1:0] acc_data_t;

    // Supported operations
    typedef enum logic [`SNAX_OP_WIDTH-1:0] {
        OP_ADD = `SNAX_OP_ADD,
        OP_SUB = `SNAX_OP_SUB,
        OP_AND = `SNAX_OP_AND,
        OP_OR  = `SNAX_OP_OR,
        OP_XOR = `SNAX_OP_XOR,
        // Low half of the product
        OP_MUL = `SNAX_OP_MUL,
        // Accumulate product, return new sum
        OP_MAC = `SNAX_OP_MAC,
        // Return sum, then zero it
        OP_CLR = `SNAX_OP_CLR
    } acc_op_e;

    // ------------------------------
    // Channel payloads
    // ------------------------------

    // Request as issued by the core
    typedef struct packed {
        acc_addr_t   addr;
        acc_id_t     id;
        logic [31:0] data_op;
        acc_data_t   data_arga;
        acc_data_t   data_argb;
    } acc_req_t;

    // Decoded command, decoder to datapath
    typedef struct packed {
        acc_id_t   id;
        acc_op_e   op;
        logic      illegal;
        acc_data_t arga;
        acc_data_t argb;
    } acc_cmd_t;

    // Response back to the core
    typedef struct packed {
        acc_id_t   id;
        logic      error;
        acc_data_t data;
    } acc_rsp_t;

endpackage

/* logic/acc_offload_decoder.sv */
`timescale 1ns/1ps

`include "snax_macros.svh"

module acc_offload_decoder (
    input  logic               clk_i,
    input  logic               rst_n_i,
    // Request from the core
    input  snax_pkg::acc_req_t req_i,
    input  logic               req_valid_i,
    output logic               req_ready_o,
    // Command towards the request queue
    output snax_pkg::acc_cmd_t cmd_o,
    output logic               cmd_valid_o,
    input  logic               cmd_ready_i
);

    import snax_pkg::*;

    // ------------------------------
    // Decode
    // ------------------------------
    logic     addr_hit;
    logic     op_upper_clear;
    logic     op_in_range;
    logic     illegal;
    acc_cmd_t cmd_d;

    // Output register
    acc_cmd_t cmd_q;
    logic     cmd_valid_q;
    logic     req_fire;

    // Target must match this accelerator
    assign addr_hit = (req_i.addr == acc_addr_t'(`SNAX_ACC_ADDR));

    // Only the low nibble may carry bits
    assign op_upper_clear = (req_i.data_op[31:`SNAX_OP_WIDTH] == '0);

    // CLR is the highest defined opcode
    assign op_in_range = (req_i.data_op[`SNAX_OP_WIDTH-1:0] <= `SNAX_OP_CLR);

    assign illegal = ~(addr_hit & op_upper_clear & op_in_range);

    always_comb begin
        cmd_d.id      = req_i.id;
        cmd_d.illegal = illegal;
        cmd_d.arga    = req_i.data_arga;
        cmd_d.argb    = req_i.data_argb;
        // Park illegal requests on a harmless opcode
        if (illegal) begin
            cmd_d.op = OP_ADD;
        end else begin
            cmd_d.op = acc_op_e'(req_i.data_op[`SNAX_OP_WIDTH-1:0]);
        end
    end

    // ------------------------------
    // Handshake
    // ------------------------------

    // Free when empty or draining this cycle
    assign req_ready_o = ~cmd_valid_q | cmd_ready_i;
    assign req_fire    = req_valid_i & req_ready_o;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cmd_valid_q <= 1'b0;
        end else if (req_ready_o) begin
            cmd_valid_q <= req_valid_i;
        end
    end

    // Capture decoded command
    always_ff @(posedge clk_i) begin
        if (req_fire) begin
            cmd_q <= cmd_d;
        end
    end

    assign cmd_o       = cmd_q;
    assign cmd_valid_o = cmd_valid_q;

endmodule

/* logic/acc_fifo.sv */
`timescale 1ns/1ps

module acc_fifo #(
    parameter type         item_t = logic,
    parameter int unsigned DEPTH  = 4
) (
    input  logic  clk_i,
    input  logic  rst_n_i,
    // Write side
    input  item_t push_data_i,
    input  logic  push_valid_i,
    output logic  push_ready_o,
    // Read side
    output item_t pop_data_o,
    output logic  pop_valid_o,
    input  logic  pop_ready_i
);

    // ------------------------------
    // Sizing
    // ------------------------------
    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    // Storage and pointers
    item_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;

    // Status and transfers
    logic full;
    logic empty;
    logic push_fire;
    logic pop_fire;

    // Advance a pointer, wrapping at the last slot
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full  = (count_q == CNT_W'(DEPTH));
    assign empty = (count_q == '0);

    // Full queue still takes an item when one leaves
    assign push_ready_o = ~full | pop_ready_i;
    assign pop_valid_o  = ~empty;
    assign pop_data_o   = mem[rd_ptr_q];

    assign push_fire = push_valid_i & push_ready_o;
    assign pop_fire  = pop_valid_o & pop_ready_i;

    // ------------------------------
    // Pointers and occupancy
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_fire) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (pop_fire) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            // Count moves only on one-sided transfers
            case ({push_fire, pop_fire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Write port
    always_ff @(posedge clk_i) begin
        if (push_fire) begin
            mem[wr_ptr_q] <= push_data_i;
        end
    end

endmodule

/* logic/acc_datapath.sv */
`timescale 1ns/1ps

module acc_datapath (
    input  logic               clk_i,
    input  logic               rst_n_i,
    // Command from the request queue
    input  snax_pkg::acc_cmd_t cmd_i,
    input  logic               cmd_valid_i,
    output logic               cmd_ready_o,
    // Response towards the response queue
    output snax_pkg::acc_rsp_t rsp_o,
    output logic               rsp_valid_o,
    input  logic               rsp_ready_i
);

    import snax_pkg::*;

    // ------------------------------
    // Arithmetic
    // ------------------------------
    acc_data_t product;
    acc_data_t result;
    acc_data_t acc_d;
    logic      acc_we;
    acc_rsp_t  rsp_d;

    // Accumulator and output register
    acc_data_t acc_q;
    acc_rsp_t  rsp_q;
    logic      rsp_valid_q;
    logic      cmd_fire;

    // Only the low half of the product is kept
    assign product = cmd_i.arga * cmd_i.argb;

    always_comb begin
        result = '0;
        acc_d  = acc_q;
        acc_we = 1'b0;
        // Illegal commands give zero and leave the sum alone
        if (!cmd_i.illegal) begin
            case (cmd_i.op)
                OP_ADD: result = cmd_i.arga + cmd_i.argb;
                OP_SUB: result = cmd_i.arga - cmd_i.argb;
                OP_AND: result = cmd_i.arga & cmd_i.argb;
                OP_OR:  result = cmd_i.arga | cmd_i.argb;
                OP_XOR: result = cmd_i.arga ^ cmd_i.argb;
                OP_MUL: result = product;
                OP_MAC: begin
                    // Return the updated sum
                    acc_d  = acc_q + product;
                    acc_we = 1'b1;
                    result = acc_d;
                end
                OP_CLR: begin
                    // Old sum out, then cleared
                    acc_d  = '0;
                    acc_we = 1'b1;
                    result = acc_q;
                end
                default: result = '0;
            endcase
        end
    end

    // Response word for this command
    always_comb begin
        rsp_d.id    = cmd_i.id;
        rsp_d.error = cmd_i.illegal;
        rsp_d.data  = result;
    end

    // ------------------------------
    // Handshake and state
    // ------------------------------

    // Take a command when the output slot frees up
    assign cmd_ready_o = ~rsp_valid_q | rsp_ready_i;
    assign cmd_fire    = cmd_valid_i & cmd_ready_o;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rsp_valid_q <= 1'b0;
            acc_q       <= '0;
        end else begin
            if (cmd_ready_o) begin
                rsp_valid_q <= cmd_valid_i;
            end
            // MAC and CLR only
            if (cmd_fire && acc_we) begin
                acc_q <= acc_d;
            end
        end
    end

    // Result register
    always_ff @(posedge clk_i) begin
        if (cmd_fire) begin
            rsp_q <= rsp_d;
        end
    end

    assign rsp_o       = rsp_q;
    assign rsp_valid_o = rsp_valid_q;

endmodule

/* logic/snax_shell.sv */
`timescale 1ns/1ps

`include "snax_macros.svh"

module snax_shell (
    input  logic               clk_i,
    input  logic               rst_n_i,
    // Offload request channel
    input  snax_pkg::acc_req_t acc_req_i,
    input  logic               acc_qvalid_i,
    output logic               acc_qready_o,
    // Offload response channel
    output snax_pkg::acc_rsp_t acc_rsp_o,
    output logic               acc_pvalid_o,
    input  logic               acc_pready_i
);

    import snax_pkg::*;

    // ------------------------------
    // Internal channels
    // ------------------------------

    // Decoder to command queue
    acc_cmd_t dec_cmd;
    logic     dec_cmd_valid;
    logic     dec_cmd_ready;

    // Command queue to datapath
    acc_cmd_t dp_cmd;
    logic     dp_cmd_valid;
    logic     dp_cmd_ready;

    // Datapath to response queue
    acc_rsp_t dp_rsp;
    logic     dp_rsp_valid;
    logic     dp_rsp_ready;

    // ------------------------------
    // Request side
    // ------------------------------
    acc_offload_decoder i_decoder (
        .clk_i       ( clk_i         ),
        .rst_n_i     ( rst_n_i       ),
        .req_i       ( acc_req_i     ),
        .req_valid_i ( acc_qvalid_i  ),
        .req_ready_o ( acc_qready_o  ),
        .cmd_o       ( dec_cmd       ),
        .cmd_valid_o ( dec_cmd_valid ),
        .cmd_ready_i ( dec_cmd_ready )
    );

    // Pending commands
    acc_fifo #(
        .item_t ( acc_cmd_t         ),
        .DEPTH  ( `SNAX_QUEUE_DEPTH )
    ) i_cmd_queue (
        .clk_i        ( clk_i         ),
        .rst_n_i      ( rst_n_i       ),
        .push_data_i  ( dec_cmd       ),
        .push_valid_i ( dec_cmd_valid ),
        .push_ready_o ( dec_cmd_ready ),
        .pop_data_o   ( dp_cmd        ),
        .pop_valid_o  ( dp_cmd_valid  ),
        .pop_ready_i  ( dp_cmd_ready  )
    );

    // ------------------------------
    // Execute and respond
    // ------------------------------
    acc_datapath i_datapath (
        .clk_i       ( clk_i        ),
        .rst_n_i     ( rst_n_i      ),
        .cmd_i       ( dp_cmd       ),
        .cmd_valid_i ( dp_cmd_valid ),
        .cmd_ready_o ( dp_cmd_ready ),
        .rsp_o       ( dp_rsp       ),
        .rsp_valid_o ( dp_rsp_valid ),
        .rsp_ready_i ( dp_rsp_ready )
    );

    // Finished results, drained by the core
    acc_fifo #(
        .item_t ( acc_rsp_t         ),
        .DEPTH  ( `SNAX_QUEUE_DEPTH )
    ) i_rsp_queue (
        .clk_i        ( clk_i        ),
        .rst_n_i      ( rst_n_i      ),
        .push_data_i  ( dp_rsp       ),
        .push_valid_i ( dp_rsp_valid ),
        .push_ready_o ( dp_rsp_ready ),
        .pop_data_o   ( acc_rsp_o    ),
        .pop_valid_o  ( acc_pvalid_o ),
        .pop_ready_i  ( acc_pready_i )
    );

endmodule

/* bench/tb_snax_shell.sv */
`timescale 1ns/1ps

`include "snax_macros.svh"

module tb_snax_shell;

    import snax_pkg::*;

    localparam int        CLK_PERIOD = 40;
    localparam int        DRIVE_DLY  = 2;
    localparam int        MAX_CYCLES = 6000;
    localparam acc_addr_t ACC_ADDR   = acc_addr_t'(`SNAX_ACC_ADDR);

    // DUT ports
    logic     clk;
    logic     rst_n;
    acc_req_t acc_req;
    logic     acc_qvalid;
    logic     acc_qready;
    acc_rsp_t acc_rsp;
    logic     acc_pvalid;
    logic     acc_pready;

    // Consumer ready mode is 0 low, 1 high or 2 random
    int unsigned pready_mode;
    int unsigned cycle_cnt = 0;

    // Reference model state
    acc_data_t               model_acc;
    acc_req_t                stim_q[$];
    acc_rsp_t                exp_q[$];
    logic [`SNAX_ID_WIDTH-1:0] next_id;
    int unsigned             sent_cnt;

    // Per-test results
    string       cur_test;
    int unsigned test_errs;
    int unsigned tests_passed;
    int unsigned tests_failed;

    snax_shell dut0 (
        .clk_i        ( clk        ),
        .rst_n_i      ( rst_n      ),
        .acc_req_i    ( acc_req    ),
        .acc_qvalid_i ( acc_qvalid ),
        .acc_qready_o ( acc_qready ),
        .acc_rsp_o    ( acc_rsp    ),
        .acc_pvalid_o ( acc_pvalid ),
        .acc_pready_i ( acc_pready )
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Run stopped: tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    // Consumer ready high about 3 in 4 cycles when random
    always @(posedge clk) begin
        #DRIVE_DLY;
        case (pready_mode)
            0:       acc_pready = 1'b0;
            1:       acc_pready = 1'b1;
            default: acc_pready = (($urandom % 4) != 0);
        endcase
    end

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic acc_rsp_t model_rsp(input acc_req_t r);
        acc_rsp_t  rsp;
        acc_data_t prod;
        logic      bad;
        prod = r.data_arga * r.data_argb;
        bad  = (r.addr != ACC_ADDR) || (r.data_op[31:4] != '0) || (r.data_op[3:0] > 4'd7);
        rsp.id    = r.id;
        rsp.error = bad;
        rsp.data  = '0;
        // Illegal requests leave the model sum alone
        if (!bad) begin
            case (acc_op_e'(r.data_op[3:0]))
                OP_ADD: rsp.data = r.data_arga + r.data_argb;
                OP_SUB: rsp.data = r.data_arga - r.data_argb;
                OP_AND: rsp.data = r.data_arga & r.data_argb;
                OP_OR:  rsp.data = r.data_arga | r.data_argb;
                OP_XOR: rsp.data = r.data_arga ^ r.data_argb;
                OP_MUL: rsp.data = prod;
                OP_MAC: begin
                    model_acc = model_acc + prod;
                    rsp.data  = model_acc;
                end
                OP_CLR: begin
                    rsp.data  = model_acc;
                    model_acc = '0;
                end
                default: rsp.data = '0;
            endcase
        end
        return rsp;
    endfunction

    function automatic acc_data_t rand64();
        return {$urandom, $urandom};
    endfunction

    // Queue a request and its expected response
    task automatic queue_req(input acc_addr_t addr, input logic [31:0] op_word,
                             input acc_data_t a, input acc_data_t b);
        acc_req_t r;
        r.addr      = addr;
        r.id        = next_id;
        r.data_op   = op_word;
        r.data_arga = a;
        r.data_argb = b;
        next_id     = next_id + 1'b1;
        stim_q.push_back(r);
        exp_q.push_back(model_rsp(r));
    endtask

    // ------------------------------
    // Channel drivers
    // ------------------------------

    // Called just after a rising edge and returns likewise
    task automatic send_req(input acc_req_t r);
        logic taken;
        acc_req    = r;
        acc_qvalid = 1'b1;
        do begin
            @(negedge clk);
            taken = acc_qready;
            @(posedge clk);
            #DRIVE_DLY;
        end while (!taken);
        acc_qvalid = 1'b0;
        sent_cnt   = sent_cnt + 1;
    endtask

    task automatic send_all();
        while (stim_q.size() > 0) begin
            send_req(stim_q.pop_front());
        end
    endtask

    // Responses must come back in request order
    task automatic recv_all(input int unsigned n);
        acc_rsp_t got;
        repeat (n) begin
            do @(negedge clk); while (!(acc_pvalid && acc_pready));
            got = acc_rsp;
            check_rsp(exp_q.pop_front(), got);
            @(posedge clk);
        end
    endtask

    task automatic run_batch();
        int unsigned n;
        n = exp_q.size();
        @(posedge clk);
        #DRIVE_DLY;
        fork
            send_all();
            recv_all(n);
        join
    endtask

    // ------------------------------
    // Checks and reporting
    // ------------------------------
    task automatic check_rsp(input acc_rsp_t exp, input acc_rsp_t act);
        if (act !== exp) begin
            $display("ERROR %s: expected id=%0d error=%0b data=%h, actual id=%0d error=%0b data=%h",
                     cur_test, exp.id, exp.error, exp.data, act.id, act.error, act.data);
            test_errs++;
        end
    endtask

    task automatic check_level(input logic exp, input logic act, input string what);
        if (act !== exp) begin
            $display("ERROR %s: %s expected %0b, actual %0b", cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic finish_test();
        if (test_errs == 0) begin
            tests_passed++;
            $display("%s: passed", cur_test);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", cur_test, test_errs);
        end
        test_errs = 0;
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------
    task automatic after_reset();
        cur_test = "after_reset";
        @(negedge clk);
        check_level(1'b0, acc_pvalid, "acc_pvalid_o");
        check_level(1'b1, acc_qready, "acc_qready_o");
        finish_test();
    endtask

    task automatic alu_ops();
        cur_test = "alu_ops";
        for (int i = OP_ADD; i <= OP_MUL; i++) begin
            queue_req(ACC_ADDR, 32'(i), rand64(), rand64());
        end
        run_batch();
        finish_test();
    endtask

    // Running sums, clear, then a fresh start
    task automatic mac_chain();
        cur_test = "mac_chain";
        repeat (4) queue_req(ACC_ADDR, 32'(OP_MAC), rand64(), rand64());
        queue_req(ACC_ADDR, 32'(OP_CLR), rand64(), rand64());
        queue_req(ACC_ADDR, 32'(OP_MAC), rand64(), rand64());
        run_batch();
        finish_test();
    endtask

    task automatic illegal_reqs();
        cur_test = "illegal_reqs";
        queue_req(ACC_ADDR + 2'd1, 32'(OP_ADD), rand64(), rand64());
        queue_req(ACC_ADDR, 32'd9, rand64(), rand64());
        queue_req(ACC_ADDR, 32'h0001_0006, rand64(), rand64());
        // Sum must be as before the bad requests
        queue_req(ACC_ADDR, 32'(OP_MAC), rand64(), rand64());
        run_batch();
        finish_test();
    endtask

    // Shell holds 2 x depth + 2 items and the rest wait
    task automatic backpressure_burst();
        int unsigned n;
        cur_test = "backpressure_burst";
        for (int i = 0; i < 14; i++) begin
            queue_req(ACC_ADDR, 32'($urandom_range(0, 7)), rand64(), rand64());
        end
        n           = exp_q.size();
        sent_cnt    = 0;
        pready_mode = 0;
        @(posedge clk);
        #DRIVE_DLY;
        fork
            send_all();
            recv_all(n);
            begin
                // Hold the consumer off until the shell stops taking requests
                do @(negedge clk); while (acc_qready);
                check_level(1'b1, sent_cnt == 2 * `SNAX_QUEUE_DEPTH + 2, "shell fill level");
                pready_mode = 1;
            end
        join
        finish_test();
    endtask

    task automatic random_mix();
        acc_addr_t   addr;
        logic [31:0] op_word;
        cur_test = "random_mix";
        for (int i = 0; i < 40; i++) begin
            addr    = (($urandom % 8) == 0) ? ACC_ADDR + 2'd1 : ACC_ADDR;
            op_word = 32'($urandom_range(0, 9));
            // Occasional junk in the upper bits
            if (($urandom % 10) == 0) begin
                op_word = op_word | 32'h0000_0100;
            end
            queue_req(addr, op_word, rand64(), rand64());
        end
        pready_mode = 2;
        run_batch();
        pready_mode = 1;
        finish_test();
    endtask

    initial begin
        void'($urandom(32'hde53));
        rst_n        = 1'b0;
        acc_req      = '0;
        acc_qvalid   = 1'b0;
        acc_pready   = 1'b1;
        pready_mode  = 1;
        model_acc    = '0;
        next_id      = '0;
        sent_cnt     = 0;
        test_errs    = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (4) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        after_reset();
        alu_ops();
        mac_chain();
        illegal_reqs();
        backpressure_burst();
        random_mix();
        $display("Summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+logic
logic/snax_pkg.sv
logic/acc_offload_decoder.sv
logic/acc_fifo.sv
logic/acc_datapath.sv
logic/snax_shell.sv
bench/tb_snax_shell.sv

/* Makefile */
TOP  := tb_snax_shell
BIN  := obj_dir/V$(TOP)
SRCS := $(shell grep -v '^+' compile.f) logic/snax_macros.svh

.PHONY: run clean

# Pass only when the testbench prints its pass line
run: $(BIN)
	@out=$$(./$(BIN)); echo "$$out"; echo "$$out" | grep -q '^Test OK$$'

# Rebuilt only when a source or the file list changes
$(BIN): compile.f $(SRCS)
	verilator --binary --timing -Wno-fatal -f compile.f --top-module $(TOP) -Mdir obj_dir

clean:
	rm -rf obj_dir
